// File: verilog/core_pkg.sv
/*
 * Shared definitions for the bridge-side logic of the emulator core.
 * Holds the bus widths, the address windows, the register map and the
 * data-table entries, plus the union for a 32-bit bridge word.
 */
package core_pkg;

  ////////////////////////////////////////
  // bus widths

  localparam int BRIDGE_W = 32;
  localparam int HALF_W   = 16;
  localparam int PIXEL_W  = 24;

  ////////////////////////////////////////
  // bridge address map

  // top address nibble that selects the rom loader
  localparam logic [3:0] ROM_WINDOW = 4'h1;

  // bit 0 is multitap
  localparam logic [BRIDGE_W-1:0] REG_SETTINGS = 32'h0000_0100;
  // read only, captured rom file size
  localparam logic [BRIDGE_W-1:0] REG_ROM_SIZE = 32'h0000_0104;

  ////////////////////////////////////////
  // host data table

  localparam int DT_ADDR_W = 10;
  localparam logic [DT_ADDR_W-1:0] DT_ROM_SIZE_ADDR  = 10'd1;
  localparam logic [DT_ADDR_W-1:0] DT_SAVE_SIZE_ADDR = 10'd3;

  // save size is this value shifted by the size code, code 0 means none
  localparam logic [BRIDGE_W-1:0] SAVE_SIZE_BASE = 32'd1024;

  // bridge word, seen whole or as two big-endian halfwords
  typedef union packed {
    logic [BRIDGE_W-1:0] word;
    struct packed {
      logic [HALF_W-1:0] hi;
      logic [HALF_W-1:0] lo;
    } half;
  } bridge_word_u;

endpackage

// File: verilog/bridge_regs.sv
/*
 * Bridge register block. Holds the multitap setting and returns
 * registered read data for the settings and rom size registers.
 */
module bridge_regs (
  input  logic                          clk_74a,
  input  logic                          pll_core_locked,
  input  logic [core_pkg::BRIDGE_W-1:0] bridge_addr,
  input  logic                          bridge_rd,
  input  logic                          bridge_wr,
  input  logic [core_pkg::BRIDGE_W-1:0] bridge_wr_data,
  input  logic [core_pkg::BRIDGE_W-1:0] rom_file_size,
  output logic [core_pkg::BRIDGE_W-1:0] bridge_rd_data,
  output logic                          multitap_enabled
);

  // read value selected by address, before the output register
  logic [core_pkg::BRIDGE_W-1:0] rd_mux;

  ////////////////////////////////////////
  // settings register

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      multitap_enabled <= 1'b0;
    end else if (bridge_wr && (bridge_addr == core_pkg::REG_SETTINGS)) begin
      // only bit 0 is defined
      multitap_enabled <= bridge_wr_data[0];
    end
  end

  ////////////////////////////////////////
  // read back

  always_comb begin
    rd_mux = '0;
    case (bridge_addr)
      core_pkg::REG_SETTINGS: begin
        rd_mux = {{(core_pkg::BRIDGE_W - 1){1'b0}}, multitap_enabled};
      end
      core_pkg::REG_ROM_SIZE: begin
        rd_mux = rom_file_size;
      end
      default: begin
        // unmapped addresses read as zero
        rd_mux = '0;
      end
    endcase
  end

  // data valid the cycle after bridge_rd
  always_ff @(posedge clk_74a) begin
    if (bridge_rd) begin
      bridge_rd_data <= rd_mux;
    end
  end

  // host issues one access at a time, a read and a write
  // in the same cycle would return stale settings
  a_rd_wr_excl : assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    !(bridge_rd && bridge_wr)
  );

endmodule

// File: verilog/rom_loader.sv
/*
 * ROM loader. Turns bridge writes in the rom window into a stream of
 * 16-bit memory writes, hi half first, paced by credits from the memory side.
 */
module rom_loader #(
  parameter int ROM_ADDR_W   = 25,
  parameter int LOAD_CREDITS = 4
) (
  input  logic                          clk_74a,
  input  logic                          pll_core_locked,
  input  logic [core_pkg::BRIDGE_W-1:0] bridge_addr,
  input  logic                          bridge_wr,
  input  logic [core_pkg::BRIDGE_W-1:0] bridge_wr_data,
  input  logic                          mem_credit,
  output logic                          mem_wr,
  output logic [ROM_ADDR_W-1:0]         mem_addr,
  output logic [core_pkg::HALF_W-1:0]   mem_data
);

  // queue depth equals the credit count, a power of two of at least 2
  localparam int PTR_W = $clog2(LOAD_CREDITS);
  localparam int CNT_W = $clog2(LOAD_CREDITS + 1);

  core_pkg::bridge_word_u wr_word;
  logic                          accept;
  logic [ROM_ADDR_W-1:0]         wr_offset;
  logic [ROM_ADDR_W-1:0]         q_addr [LOAD_CREDITS];
  logic [core_pkg::HALF_W-1:0]   q_data [LOAD_CREDITS];
  logic [PTR_W-1:0]              wr_ptr;
  logic [PTR_W-1:0]              wr_ptr_lo;
  logic [PTR_W-1:0]              rd_ptr;
  logic [CNT_W-1:0]              q_count;
  logic [CNT_W-1:0]              credits;
  logic                          pop;

  ////////////////////////////////////////
  // window decode and word split

  assign wr_word.word = bridge_wr_data;
  assign accept = bridge_wr &&
                  (bridge_addr[core_pkg::BRIDGE_W-1 -: 4] == core_pkg::ROM_WINDOW);
  // byte offset inside the rom
  assign wr_offset = bridge_addr[ROM_ADDR_W-1:0];
  // lo half lands in the slot after hi
  assign wr_ptr_lo = wr_ptr + PTR_W'(1);

  // big-endian bridge, hi half at the lower address
  always_ff @(posedge clk_74a) begin
    if (accept) begin
      q_addr[wr_ptr]    <= wr_offset;
      q_data[wr_ptr]    <= wr_word.half.hi;
      q_addr[wr_ptr_lo] <= wr_offset + ROM_ADDR_W'(2);
      q_data[wr_ptr_lo] <= wr_word.half.lo;
    end
  end

  ////////////////////////////////////////
  // issue and credit tracking

  // head goes out whenever a credit is left
  assign pop      = (q_count != '0) && (credits != '0);
  assign mem_wr   = pop;
  assign mem_addr = q_addr[rd_ptr];
  assign mem_data = q_data[rd_ptr];

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      q_count <= '0;
      credits <= CNT_W'(LOAD_CREDITS);
    end else begin
      if (accept) begin
        wr_ptr <= wr_ptr + PTR_W'(2);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + PTR_W'(1);
      end
      // two entries in per word, one out per strobe
      q_count <= q_count + (accept ? CNT_W'(2) : CNT_W'(0)) - CNT_W'(pop);
      // one credit spent per strobe, one back per pulse
      credits <= credits - CNT_W'(pop) + CNT_W'(mem_credit);
    end
  end

  // bridge cannot stall, so every word must find two free slots
  a_no_overflow : assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    accept |-> ((q_count - CNT_W'(pop)) <= CNT_W'(LOAD_CREDITS - 2))
  );

  // memory side returns no more credits than strobes it saw
  a_credit_max : assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    credits <= CNT_W'(LOAD_CREDITS)
  );

endmodule

// File: verilog/datatable_seq.sv
/*
 * Data-table sequencer. Runs a fixed 8-cycle frame that reads the rom
 * size entry and writes the save size decoded from the 4-bit code.
 */
module datatable_seq (
  input  logic                           clk_74a,
  input  logic                           pll_core_locked,
  input  logic [core_pkg::BRIDGE_W-1:0]  dt_q,
  input  logic [3:0]                     save_size_code,
  output logic [core_pkg::DT_ADDR_W-1:0] dt_addr,
  output logic                           dt_wren,
  output logic [core_pkg::BRIDGE_W-1:0]  dt_data,
  output logic [core_pkg::BRIDGE_W-1:0]  rom_file_size
);

  logic [2:0]                    phase;
  logic [core_pkg::BRIDGE_W-1:0] save_size;

  // code 0 means no save memory
  assign save_size = (save_size_code == 4'd0) ? '0 :
                     (core_pkg::SAVE_SIZE_BASE << save_size_code);

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      phase         <= '0;
      dt_addr       <= '0;
      dt_wren       <= 1'b0;
      rom_file_size <= '0;
    end else begin
      phase <= phase + 3'd1;
      if (phase > 3'd4) begin
        // phases 5 to 7 write the save size
        dt_wren <= 1'b1;
        dt_addr <= core_pkg::DT_SAVE_SIZE_ADDR;
      end else begin
        dt_wren <= 1'b0;
        dt_addr <= core_pkg::DT_ROM_SIZE_ADDR;
        // entry has been on the bus long enough by now
        if (phase == 3'd4) begin
          rom_file_size <= dt_q;
        end
      end
    end
  end

  always_ff @(posedge clk_74a) begin
    dt_data <= save_size;
  end

  // each write burst is three cycles long, all to the save entry
  a_wr_burst : assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    $rose(dt_wren) |->
      (dt_wren && (dt_addr == core_pkg::DT_SAVE_SIZE_ADDR))[*3] ##1 !dt_wren
  );

endmodule

// File: verilog/video_cond.sv
/*
 * Video conditioning. Derives display enable from the blanking inputs,
 * blanks pixels outside the active area and turns syncs into edge pulses.
 */
module video_cond (
  input  logic                         clk_74a,
  input  logic                         pll_core_locked,
  input  logic                         raw_hblank,
  input  logic                         raw_vblank,
  input  logic                         raw_hs,
  input  logic                         raw_vs,
  input  logic [core_pkg::PIXEL_W-1:0] raw_rgb,
  output logic                         video_de,
  output logic                         video_hs,
  output logic                         video_vs,
  output logic [core_pkg::PIXEL_W-1:0] video_rgb
);

  logic active;
  logic hs_prev;
  logic vs_prev;

  assign active = !(raw_hblank || raw_vblank);

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      video_de <= 1'b0;
      video_hs <= 1'b0;
      video_vs <= 1'b0;
      hs_prev  <= 1'b0;
      vs_prev  <= 1'b0;
    end else begin
      video_de <= active;
      // single-cycle pulse on each rising sync
      video_hs <= raw_hs && !hs_prev;
      video_vs <= raw_vs && !vs_prev;
      hs_prev  <= raw_hs;
      vs_prev  <= raw_vs;
    end
  end

  // black outside the active area
  always_ff @(posedge clk_74a) begin
    video_rgb <= active ? raw_rgb : '0;
  end

endmodule

// File: verilog/core_top.sv
/*
 * Top level of the bridge-side core logic. Connects the register
 * block, rom loader, data-table sequencer and video conditioning.
 */
module core_top #(
  parameter int ROM_ADDR_W   = 25,
  parameter int LOAD_CREDITS = 4
) (
  input  logic                           clk_74a,
  input  logic                           pll_core_locked,
  // bridge bus
  input  logic [core_pkg::BRIDGE_W-1:0]  bridge_addr,
  input  logic                           bridge_rd,
  input  logic                           bridge_wr,
  input  logic [core_pkg::BRIDGE_W-1:0]  bridge_wr_data,
  output logic [core_pkg::BRIDGE_W-1:0]  bridge_rd_data,
  output logic                           multitap_enabled,
  // rom write stream
  input  logic                           mem_credit,
  output logic                           mem_wr,
  output logic [ROM_ADDR_W-1:0]          mem_addr,
  output logic [core_pkg::HALF_W-1:0]    mem_data,
  // host data table
  input  logic [core_pkg::BRIDGE_W-1:0]  dt_q,
  input  logic [3:0]                     save_size_code,
  output logic [core_pkg::DT_ADDR_W-1:0] dt_addr,
  output logic                           dt_wren,
  output logic [core_pkg::BRIDGE_W-1:0]  dt_data,
  // video
  input  logic                           raw_hblank,
  input  logic                           raw_vblank,
  input  logic                           raw_hs,
  input  logic                           raw_vs,
  input  logic [core_pkg::PIXEL_W-1:0]   raw_rgb,
  output logic                           video_de,
  output logic                           video_hs,
  output logic                           video_vs,
  output logic [core_pkg::PIXEL_W-1:0]   video_rgb
);

  // size read from the data table, returned on the bridge
  logic [core_pkg::BRIDGE_W-1:0] rom_file_size;

  ////////////////////////////////////////
  // bridge side

  bridge_regs u_regs (
    .clk_74a          (clk_74a),
    .pll_core_locked  (pll_core_locked),
    .bridge_addr      (bridge_addr),
    .bridge_rd        (bridge_rd),
    .bridge_wr        (bridge_wr),
    .bridge_wr_data   (bridge_wr_data),
    .rom_file_size    (rom_file_size),
    .bridge_rd_data   (bridge_rd_data),
    .multitap_enabled (multitap_enabled)
  );

  rom_loader #(
    .ROM_ADDR_W   (ROM_ADDR_W),
    .LOAD_CREDITS (LOAD_CREDITS)
  ) u_loader (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .bridge_addr     (bridge_addr),
    .bridge_wr       (bridge_wr),
    .bridge_wr_data  (bridge_wr_data),
    .mem_credit      (mem_credit),
    .mem_wr          (mem_wr),
    .mem_addr        (mem_addr),
    .mem_data        (mem_data)
  );

  datatable_seq u_dtseq (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .dt_q            (dt_q),
    .save_size_code  (save_size_code),
    .dt_addr         (dt_addr),
    .dt_wren         (dt_wren),
    .dt_data         (dt_data),
    .rom_file_size   (rom_file_size)
  );

  ////////////////////////////////////////
  // video

  video_cond u_video (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .raw_hblank      (raw_hblank),
    .raw_vblank      (raw_vblank),
    .raw_hs          (raw_hs),
    .raw_vs          (raw_vs),
    .raw_rgb         (raw_rgb),
    .video_de        (video_de),
    .video_hs        (video_hs),
    .video_vs        (video_vs),
    .video_rgb       (video_rgb)
  );

endmodule

// File: verif/tb_clock.sv
/*
 * Testbench clock source, free running from time zero.
 */
module tb_clock #(
  parameter int PERIOD = 8
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

endmodule

// File: verif/core_top_tb.sv
/*
 * Testbench for the bridge-side core logic. Drives bridge accesses, models
 * the rom memory side and the host data table, and checks the DUT with
 * concurrent assertions.
 */
module core_top_tb;

  localparam int ROM_ADDR_W   = 25;
  localparam int LOAD_CREDITS = 4;
  localparam int WAIT_LIMIT   = 500;
  // what wait_until waits for
  localparam int W_ROOM    = 0;
  localparam int W_DRAINED = 1;
  localparam int W_CREDITS = 2;

  logic                           clk_74a;
  logic                           pll_core_locked;
  logic [core_pkg::BRIDGE_W-1:0]  bridge_addr;
  logic                           bridge_rd;
  logic                           bridge_wr;
  logic [core_pkg::BRIDGE_W-1:0]  bridge_wr_data;
  logic [core_pkg::BRIDGE_W-1:0]  bridge_rd_data;
  logic                           multitap_enabled;
  logic                           mem_credit = 1'b0;
  logic                           mem_wr;
  logic [ROM_ADDR_W-1:0]          mem_addr;
  logic [core_pkg::HALF_W-1:0]    mem_data;
  logic [core_pkg::BRIDGE_W-1:0]  dt_q = '0;
  logic [3:0]                     save_size_code;
  logic [core_pkg::DT_ADDR_W-1:0] dt_addr;
  logic                           dt_wren;
  logic [core_pkg::BRIDGE_W-1:0]  dt_data;
  logic                           raw_hblank = 1'b1;
  logic                           raw_vblank = 1'b1;
  logic                           raw_hs = 1'b0;
  logic                           raw_vs = 1'b0;
  logic [core_pkg::PIXEL_W-1:0]   raw_rgb = '0;
  logic                           video_de;
  logic                           video_hs;
  logic                           video_vs;
  logic [core_pkg::PIXEL_W-1:0]   video_rgb;

  // expected halfword stream in bridge order
  logic [ROM_ADDR_W-1:0]          exp_addr [64];
  logic [core_pkg::HALF_W-1:0]    exp_data [64];
  logic [ROM_ADDR_W-1:0]          head_addr;
  logic [core_pkg::HALF_W-1:0]    head_data;
  int                             exp_wr = 0;
  int                             exp_rd = 0;
  // strobes not yet paid back with a credit
  int                             outstanding = 0;
  logic                           hold_credits = 1'b0;
  logic [core_pkg::BRIDGE_W-1:0]  dt_table [1 << core_pkg::DT_ADDR_W];
  logic [core_pkg::BRIDGE_W-1:0]  rom_size_val;
  // cycles since the last save size write
  int                             dt_idle = 0;
  // inputs delayed one cycle to match the registered outputs
  logic                           rd_d = 1'b0;
  logic [core_pkg::BRIDGE_W-1:0]  rd_expect = '0;
  logic                           settings_wr_d = 1'b0;
  logic                           wr_bit_d = 1'b0;
  logic [core_pkg::BRIDGE_W-1:0]  exp_save_d = '0;
  logic [core_pkg::PIXEL_W-1:0]   rgb_d = '0;
  logic                           active_d;
  logic                           hs_d;
  logic                           hs_dd;
  logic                           vs_d;
  logic                           vs_dd;
  int                             value_errors = 0;
  int                             other_errors = 0;
  int                             timeouts = 0;

  tb_clock #(.PERIOD(8)) u_clock (.clk(clk_74a));

  core_top #(
    .ROM_ADDR_W   (ROM_ADDR_W),
    .LOAD_CREDITS (LOAD_CREDITS)
  ) uut (
    .clk_74a          (clk_74a),
    .pll_core_locked  (pll_core_locked),
    .bridge_addr      (bridge_addr),
    .bridge_rd        (bridge_rd),
    .bridge_wr        (bridge_wr),
    .bridge_wr_data   (bridge_wr_data),
    .bridge_rd_data   (bridge_rd_data),
    .multitap_enabled (multitap_enabled),
    .mem_credit       (mem_credit),
    .mem_wr           (mem_wr),
    .mem_addr         (mem_addr),
    .mem_data         (mem_data),
    .dt_q             (dt_q),
    .save_size_code   (save_size_code),
    .dt_addr          (dt_addr),
    .dt_wren          (dt_wren),
    .dt_data          (dt_data),
    .raw_hblank       (raw_hblank),
    .raw_vblank       (raw_vblank),
    .raw_hs           (raw_hs),
    .raw_vs           (raw_vs),
    .raw_rgb          (raw_rgb),
    .video_de         (video_de),
    .video_hs         (video_hs),
    .video_vs         (video_vs),
    .video_rgb        (video_rgb)
  );

  ////////////////////////////////////////
  // helpers

  task automatic show_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] want);
    value_errors++;
    $display("[FAIL] %s got %h expected %h", name, got, want);
  endtask

  task automatic count_fault(input string what);
    other_errors++;
    $display("error: %s", what);
  endtask

  // code 0 means no save memory
  function automatic logic [31:0] save_bytes(input logic [3:0] code);
    if (code == 4'd0) begin
      return '0;
    end
    return core_pkg::SAVE_SIZE_BASE << code;
  endfunction

  function automatic bit stream_state(input int what);
    case (what)
      W_ROOM:    return (exp_wr - exp_rd) <= (LOAD_CREDITS - 2);
      W_DRAINED: return exp_rd == exp_wr;
      default:   return outstanding == 0;
    endcase
  endfunction

  task automatic wait_until(input int what, output bit ok);
    int n;
    ok = 1'b0;
    for (n = 0; n < WAIT_LIMIT; n++) begin
      @(posedge clk_74a);
      if (stream_state(what)) begin
        ok = 1'b1;
        break;
      end
    end
    if (!ok) begin
      timeouts++;
      $display("timeout: rom stream stuck while waiting in state %0d", what);
    end
  endtask

  // one bridge write starting just after a rising edge
  task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
    logic [ROM_ADDR_W-1:0] offset;
    offset = addr[ROM_ADDR_W-1:0];
    bridge_addr    <= addr;
    bridge_wr_data <= data;
    bridge_wr      <= 1'b1;
    if (addr[31:28] == core_pkg::ROM_WINDOW) begin
      // big-endian bridge puts the hi half at the word offset
      exp_addr[exp_wr % 64]       <= offset;
      exp_data[exp_wr % 64]       <= data[31:16];
      exp_addr[(exp_wr + 1) % 64] <= offset + ROM_ADDR_W'(2);
      exp_data[(exp_wr + 1) % 64] <= data[15:0];
      exp_wr                      <= exp_wr + 2;
    end
    @(posedge clk_74a);
    bridge_wr <= 1'b0;
  endtask

  task automatic read_and_check(input logic [31:0] addr, input logic [31:0] want);
    bridge_addr <= addr;
    bridge_rd   <= 1'b1;
    rd_expect   <= want;
    @(posedge clk_74a);
    bridge_rd <= 1'b0;
    // checked on the following edge
    @(posedge clk_74a);
  endtask

  ////////////////////////////////////////
  // memory, data table and video models

  // credits come back after random delays and never exceed the strobes owed
  always @(posedge clk_74a or negedge pll_core_locked) begin : credit_model
    int avail;
    if (!pll_core_locked) begin
      outstanding <= 0;
      mem_credit  <= 1'b0;
    end else begin
      avail = outstanding + int'(mem_wr) - int'(mem_credit);
      outstanding <= avail;
      mem_credit  <= !hold_credits && (avail > 0) && ($urandom % 3 == 0);
    end
  end

  always @(posedge clk_74a) begin
    if (pll_core_locked && mem_wr) begin
      exp_rd <= exp_rd + 1;
    end
  end

  assign head_addr = exp_addr[exp_rd % 64];
  assign head_data = exp_data[exp_rd % 64];

  // host data table with one cycle read latency
  always @(posedge clk_74a) begin
    if (dt_wren) begin
      dt_table[dt_addr] <= dt_data;
    end
    dt_q <= dt_table[dt_addr];
  end

  always @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      dt_idle <= 0;
    end else if (dt_wren) begin
      dt_idle <= 0;
    end else begin
      dt_idle <= dt_idle + 1;
    end
  end

  // random video where the syncs toggle now and then
  always @(posedge clk_74a) begin : video_stim
    logic [31:0] rnd;
    rnd = $urandom;
    raw_hblank <= ($urandom % 4) == 0;
    raw_vblank <= ($urandom % 16) == 0;
    raw_rgb    <= rnd[core_pkg::PIXEL_W-1:0];
    if ($urandom % 3 == 0) begin
      raw_hs <= !raw_hs;
    end
    if ($urandom % 7 == 0) begin
      raw_vs <= !raw_vs;
    end
  end

  always @(posedge clk_74a) begin
    rd_d          <= bridge_rd;
    settings_wr_d <= bridge_wr && (bridge_addr == core_pkg::REG_SETTINGS);
    wr_bit_d      <= bridge_wr_data[0];
    exp_save_d    <= save_bytes(save_size_code);
    rgb_d         <= (raw_hblank || raw_vblank) ? '0 : raw_rgb;
  end

  always @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      active_d <= 1'b0;
      hs_d     <= 1'b0;
      hs_dd    <= 1'b0;
      vs_d     <= 1'b0;
      vs_dd    <= 1'b0;
    end else begin
      active_d <= !(raw_hblank || raw_vblank);
      hs_d     <= raw_hs;
      hs_dd    <= hs_d;
      vs_d     <= raw_vs;
      vs_dd    <= vs_d;
    end
  end

  ////////////////////////////////////////
  // checks

  a_reset : assert property (@(posedge clk_74a)
    $rose(pll_core_locked) |-> !mem_wr && !dt_wren && !video_de && !video_hs &&
      !video_vs && !multitap_enabled && (uut.rom_file_size == '0))
    else count_fault("control outputs not all low after reset");

  a_settings : assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    settings_wr_d |-> multitap_enabled == wr_bit_d)
    else show_mismatch("multitap_enabled", $sampled(multitap_enabled), $sampled(wr_bit_d));

  a_read : assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    rd_d |-> bridge_rd_data == rd_expect)
    else show_mismatch("bridge_rd_data", $sampled(bridge_rd_data), $sampled(rd_expect));

  a_stray : assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    mem_wr |-> exp_rd != exp_wr)
    else count_fault("memory strobe with no halfword left to write");

  a_mem_addr : assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    mem_wr |-> mem_addr == head_addr)
    else show_mismatch("mem_addr", $sampled(mem_addr), $sampled(head_addr));

  a_mem_data : assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    mem_wr |-> mem_data == head_data)
    else show_mismatch("mem_data", $sampled(mem_data), $sampled(head_data));

  a_in_flight : assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    outstanding <= LOAD_CREDITS)
    else count_fault("more memory writes in flight than credits");

  a_dt_addr : assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    dt_wren |-> dt_addr == core_pkg::DT_SAVE_SIZE_ADDR)
    else show_mismatch("dt_addr", $sampled(dt_addr), core_pkg::DT_SAVE_SIZE_ADDR);

  a_dt_data : assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    dt_wren |-> dt_data == exp_save_d)
    else show_mismatch("dt_data", $sampled(dt_data), $sampled(exp_save_d));

  // every 8-cycle frame carries a save size write
  a_dt_frame : assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    dt_idle < 8)
    else count_fault("no data table write during a whole frame");

  a_de : assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    video_de == active_d)
    else show_mismatch("video_de", $sampled(video_de), $sampled(active_d));

  a_rgb : assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    video_rgb == rgb_d)
    else show_mismatch("video_rgb", $sampled(video_rgb), $sampled(rgb_d));

  // one pulse per rising sync
  a_hs : assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    video_hs == (hs_d && !hs_dd))
    else show_mismatch("video_hs", $sampled(video_hs), $sampled(hs_d && !hs_dd));

  a_vs : assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    video_vs == (vs_d && !vs_dd))
    else show_mismatch("video_vs", $sampled(video_vs), $sampled(vs_d && !vs_dd));

  ////////////////////////////////////////
  // stimulus

  task automatic run_tests();
    bit          ok;
    int          i;
    logic [31:0] addr;
    @(posedge clk_74a);
    // settings register and then an unmapped read
    write_word(core_pkg::REG_SETTINGS, 32'h0000_0001);
    read_and_check(core_pkg::REG_SETTINGS, 32'h0000_0001);
    read_and_check(32'h0000_0200, '0);
    // rom stream with random credit return
    for (i = 0; i < 12; i++) begin
      wait_until(W_ROOM, ok);
      if (!ok) return;
      addr = {core_pkg::ROM_WINDOW, 28'($urandom)};
      write_word(addr, $urandom);
    end
    wait_until(W_DRAINED, ok);
    if (!ok) return;
    // half the words sit in the queue while credits are held
    wait_until(W_CREDITS, ok);
    if (!ok) return;
    hold_credits <= 1'b1;
    for (i = 0; i < LOAD_CREDITS; i++) begin
      wait_until(W_ROOM, ok);
      if (!ok) return;
      addr = {core_pkg::ROM_WINDOW, 28'($urandom)};
      write_word(addr, $urandom);
    end
    repeat (20) @(posedge clk_74a);
    hold_credits <= 1'b0;
    wait_until(W_DRAINED, ok);
    if (!ok) return;
    // three frames for each save size code
    save_size_code <= 4'd0;
    repeat (24) @(posedge clk_74a);
    save_size_code <= 4'd15;
    repeat (24) @(posedge clk_74a);
    save_size_code <= 4'(1 + $urandom % 14);
    repeat (24) @(posedge clk_74a);
    read_and_check(core_pkg::REG_ROM_SIZE, rom_size_val);
    write_word(core_pkg::REG_SETTINGS, 32'h0000_0000);
    read_and_check(core_pkg::REG_SETTINGS, 32'h0000_0000);
  endtask

  initial begin
    int i;
    void'($urandom(5181));
    pll_core_locked = 1'b0;
    bridge_addr     = '0;
    bridge_rd       = 1'b0;
    bridge_wr       = 1'b0;
    bridge_wr_data  = '0;
    save_size_code  = 4'd3;
    // fill pattern over the whole table address
    for (i = 0; i < (1 << core_pkg::DT_ADDR_W); i++) begin
      dt_table[i] = 32'hD7A0_0000 ^ (i * 32'h0004_0021);
    end
    rom_size_val = $urandom;
    dt_table[core_pkg::DT_ROM_SIZE_ADDR] = rom_size_val;
    repeat (4) @(posedge clk_74a);
    pll_core_locked <= 1'b1;
    run_tests();
    $display("errors: value %0d, other %0d, timeouts %0d",
             value_errors, other_errors, timeouts);
    if (value_errors + other_errors + timeouts == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: filelist.f
verilog/core_pkg.sv
verilog/bridge_regs.sv
verilog/rom_loader.sv
verilog/datatable_seq.sv
verilog/video_cond.sv
verilog/core_top.sv
verif/tb_clock.sv
verif/core_top_tb.sv

// File: Bender.yml
package:
  name: core_bridge

sources:
  - verilog/core_pkg.sv
  - verilog/bridge_regs.sv
  - verilog/rom_loader.sv
  - verilog/datatable_seq.sv
  - verilog/video_cond.sv
  - verilog/core_top.sv
  - target: test
    files:
      - verif/tb_clock.sv
      - verif/core_top_tb.sv
